/* src.f */
logic/core_pkg.sv
logic/reg_file.sv
logic/decode.sv
logic/execute.sv
logic/result.sv
logic/core_top.sv
bench/core_tb.sv

/* bench/core_tb.sv */
module core_tb
  import core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PC_W    = 16;
  localparam int CLK_PER = 20;
  localparam int RST_CYC = 8;
  // Strobes of all tests add up as 59 + 22 + 7 + 78 + 8 + 35
  localparam int N_INSTR = 209;

  logic              bus = 1'b0;
  logic              rst;
  logic              in_valid;
  logic [XLEN-1:0]   in_instr;
  logic [PC_W-1:0]   in_pc;
  logic              redirect_valid;
  logic [PC_W-1:0]   redirect_pc;
  logic              res_valid;
  logic [REG_AW-1:0] res_rd;
  logic [XLEN-1:0]   res_value;

  // Reference model and expected strobes tagged with their cycle
  logic [XLEN-1:0]   ref_regs [32];
  int                res_cyc_q [$];
  logic [REG_AW-1:0] res_rd_q [$];
  logic [XLEN-1:0]   res_val_q [$];
  int                rdr_cyc_q [$];
  logic [PC_W-1:0]   rdr_pc_q [$];
  logic              skip_next;
  logic [PC_W-1:0]   pc;
  int                cyc = 0;
  int                seed = 32'h2662_9b98;

  core_top #(.PC_W(PC_W)) i_dut (
    .bus, .rst, .in_valid, .in_instr, .in_pc,
    .redirect_valid, .redirect_pc, .res_valid, .res_rd, .res_value
  );

  always #(CLK_PER / 2) bus = ~bus;

  always @(posedge bus) cyc <= cyc + 1;

  ////////////////////
  // Checks

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_result(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] value);
    if (res_rd !== rd || res_value !== value) begin
      stop_run($sformatf("mismatch at %0t: result x%0d = %h, expected x%0d = %h",
                         $time, res_rd, res_value, rd, value));
    end
  endtask

  task automatic check_redirect(input logic [PC_W-1:0] target);
    if (redirect_pc !== target) begin
      stop_run($sformatf("mismatch at %0t: redirect to %h, expected %h",
                         $time, redirect_pc, target));
    end
  endtask

  // Monitors sample mid-cycle
  always @(negedge bus) begin
    if (res_valid) begin
      if (res_cyc_q.size() == 0 || res_cyc_q[0] != cyc) begin
        stop_run($sformatf("error at %0t: a result strobe came that was not expected", $time));
      end else begin
        check_result(res_rd_q[0], res_val_q[0]);
        void'(res_cyc_q.pop_front());
        void'(res_rd_q.pop_front());
        void'(res_val_q.pop_front());
      end
    end else if (res_cyc_q.size() != 0 && res_cyc_q[0] <= cyc) begin
      stop_run($sformatf("error at %0t: an expected result strobe did not come", $time));
    end
  end

  always @(negedge bus) begin
    if (redirect_valid) begin
      if (rdr_cyc_q.size() == 0 || rdr_cyc_q[0] != cyc) begin
        stop_run($sformatf("error at %0t: a redirect came that was not expected", $time));
      end else begin
        check_redirect(rdr_pc_q[0]);
        void'(rdr_cyc_q.pop_front());
        void'(rdr_pc_q.pop_front());
      end
    end else if (rdr_cyc_q.size() != 0 && rdr_cyc_q[0] <= cyc) begin
      stop_run($sformatf("error at %0t: an expected redirect did not come", $time));
    end
  end

  ////////////////////
  // Model and stimulus

  task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    res_cyc_q.delete();
    res_rd_q.delete();
    res_val_q.delete();
    rdr_cyc_q.delete();
    rdr_pc_q.delete();
    skip_next = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge bus);
      #2;
    end
  endtask

  task automatic drain();
    while (res_cyc_q.size() != 0 || rdr_cyc_q.size() != 0) begin
      @(posedge bus);
    end
    idle(4);
  endtask

  // One strobe with its result 3 cycles on and its redirect 1 cycle on
  task automatic strobe(input logic [XLEN-1:0] instr, input logic [REG_AW-1:0] rd,
                        input logic [XLEN-1:0] value, input logic jump,
                        input logic [PC_W-1:0] target);
    in_valid = 1'b1;
    in_instr = instr;
    in_pc    = pc;
    if (skip_next) begin
      skip_next = 1'b0;
    end else begin
      if (rd != '0) begin
        res_cyc_q.push_back(cyc + 3);
        res_rd_q.push_back(rd);
        res_val_q.push_back(value);
        ref_regs[rd] = value;
      end
      if (jump) begin
        rdr_cyc_q.push_back(cyc + 1);
        rdr_pc_q.push_back(target);
        skip_next = 1'b1;
      end
    end
    pc = pc + PC_W'(4);
    @(posedge bus);
    #2;
    in_valid = 1'b0;
  endtask

  // {funct7, funct3} of an ALU function
  function automatic logic [9:0] alu_fields(input alu_op_e op);
    case (op)
      SUB:     return {F7_ALT, F3_ADD};
      SLL:     return {F7_BASE, F3_SLL};
      SLT:     return {F7_BASE, F3_SLT};
      SLTU:    return {F7_BASE, F3_SLTU};
      XOR:     return {F7_BASE, F3_XOR};
      SRL:     return {F7_BASE, F3_SR};
      SRA:     return {F7_ALT, F3_SR};
      OR:      return {F7_BASE, F3_OR};
      AND:     return {F7_BASE, F3_AND};
      default: return {F7_BASE, F3_ADD};
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (op)
      ADD:     r = a + b;
      SUB:     r = a + ~b + 1'b1;
      SLL:     r = a << b[4:0];
      SLT:     r = {{(XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
      SLTU:    r = {{(XLEN - 1){1'b0}}, a < b};
      XOR:     r = a ^ b;
      SRL:     r = a >> b[4:0];
      SRA:     r = $signed(a) >>> b[4:0];
      OR:      r = a | b;
      AND:     r = a & b;
      default: r = b;
    endcase
    return r;
  endfunction

  task automatic do_alu_r(input alu_op_e op, input logic [REG_AW-1:0] rd,
                          input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2);
    logic [9:0] f;
    f = alu_fields(op);
    strobe({f[9:3], rs2, rs1, f[2:0], rd, OP}, rd,
           alu_ref(op, ref_regs[rs1], ref_regs[rs2]), 1'b0, '0);
  endtask

  task automatic do_alu_i(input alu_op_e op, input logic [REG_AW-1:0] rd,
                          input logic [REG_AW-1:0] rs1, input logic [11:0] imm);
    logic [9:0]  f;
    logic [11:0] field;
    f = alu_fields(op);
    // Shifts carry funct7 in the upper immediate bits
    field = (op == SLL || op == SRL || op == SRA) ? {f[9:3], imm[4:0]} : imm;
    strobe({field, rs1, f[2:0], rd, OP_IMM}, rd,
           alu_ref(op, ref_regs[rs1], {{20{field[11]}}, field}), 1'b0, '0);
  endtask

  task automatic do_lui(input logic [REG_AW-1:0] rd, input logic [19:0] imm);
    strobe({imm, rd, LUI}, rd, {imm, 12'b0}, 1'b0, '0);
  endtask

  task automatic do_auipc(input logic [REG_AW-1:0] rd, input logic [19:0] imm);
    strobe({imm, rd, AUIPC}, rd, XLEN'(pc) + {imm, 12'b0}, 1'b0, '0);
  endtask

  task automatic do_branch(input br_cond_e cond, input logic [REG_AW-1:0] rs1,
                           input logic [REG_AW-1:0] rs2, input logic [12:0] off);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            taken;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    case (cond)
      BEQ:     taken = a == b;
      BNE:     taken = a != b;
      BLT:     taken = $signed(a) < $signed(b);
      BGE:     taken = !($signed(a) < $signed(b));
      BLTU:    taken = a < b;
      default: taken = !(a < b);
    endcase
    strobe({off[12], off[10:5], rs2, rs1, cond, off[4:1], off[11], BRANCH}, '0, '0,
           taken, pc + PC_W'($signed(off)));
  endtask

  task automatic do_jal(input logic [REG_AW-1:0] rd, input logic [20:0] off);
    strobe({off[20], off[10:1], off[11], off[19:12], rd, JAL}, rd,
           XLEN'(pc + PC_W'(4)), 1'b1, pc + PC_W'($signed(off)));
  endtask

  task automatic do_jalr(input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
                         input logic [11:0] imm);
    logic [XLEN-1:0] sum;
    sum = ref_regs[rs1] + {{20{imm[11]}}, imm};
    strobe({imm, rs1, 3'b000, rd, JALR}, rd, XLEN'(pc + PC_W'(4)), 1'b1,
           sum[PC_W-1:0] & ~PC_W'(1));
  endtask

  // LUI then ADDI with the upper part rounded for the signed low part
  task automatic load_reg(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] value);
    do_lui(rd, value[31:12] + {19'b0, value[11]});
    do_alu_i(ADD, rd, rd, value[11:0]);
  endtask

  ////////////////////
  // Tests

  task automatic test_alu();
    logic [XLEN-1:0] r;
    alu_op_e         op;
    for (int i = 0; i <= 9; i++) begin
      op = alu_op_e'(i);
      r = $random(seed);
      load_reg(1, r);
      r = $random(seed);
      load_reg(2, r);
      idle(3);
      do_alu_r(op, 3, 1, 2);
      idle(3);
      if (op != SUB) begin
        r = $random(seed);
        do_alu_i(op, 4, 1, r[11:0]);
        idle(3);
      end
    end
    drain();
  endtask

  task automatic test_chain();
    logic [XLEN-1:0] r;
    for (int k = 0; k < 5; k++) begin
      r = $random(seed);
      load_reg(REG_AW'(5 + k), r);
    end
    idle(4);
    // Sources are the last rd and the one two or three back
    for (int k = 0; k < 12; k++) begin
      do_alu_r(alu_op_e'(k % 10), REG_AW'(5 + k % 5), REG_AW'(5 + (k + 4) % 5),
               REG_AW'(5 + (k + 3 - k % 2) % 5));
    end
    drain();
  endtask

  task automatic test_upper();
    logic [XLEN-1:0] r;
    r = $random(seed);
    do_lui(10, r[31:12]);
    pc = ~PC_W'(3);
    do_auipc(11, r[19:0]);
    do_alu_i(ADD, 0, 10, 12'h123);
    do_lui(0, r[19:0]);
    do_alu_r(ADD, 12, 0, 10);
    do_alu_r(OR, 13, 0, 0);
    idle(3);
    do_alu_r(ADD, 14, 0, 0);
    drain();
  endtask

  task automatic test_branch();
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    // Pairs chosen so every condition goes both ways
    for (int p = 0; p < 3; p++) begin
      a = (p == 0) ? XLEN'(-5) : XLEN'(3);
      b = (p == 2) ? XLEN'(-5) : XLEN'(3);
      load_reg(14, a);
      for (int c = 0; c < 6; c++) begin
        r = $random(seed);
        load_reg(15, b);
        do_branch(br_cond_e'(c < 2 ? c : c + 2), 14, 15, {r[12:1], 1'b0});
        do_alu_i(ADD, 16, 0, 12'h001);
        idle(3);
      end
    end
    drain();
  endtask

  task automatic test_jump();
    logic [XLEN-1:0] r;
    r = $random(seed);
    do_jal(1, {r[20:1], 1'b0});
    idle(5);
    do_alu_i(ADD, 2, 0, 12'h055);
    do_alu_i(ADD, 3, 0, 12'h066);
    r = $random(seed);
    load_reg(20, r);
    do_jalr(5, 20, {r[11:1], 1'b1});
    idle(4);
    do_alu_i(ADD, 6, 0, 12'h077);
    do_alu_r(ADD, 7, 5, 1);
    drain();
  endtask

  task automatic test_reset();
    logic [XLEN-1:0] r;
    r = $random(seed);
    load_reg(8, r);
    do_alu_r(ADD, 9, 8, 8);
    r = $random(seed);
    do_jal(10, {r[20:1], 1'b0});
    // Results and a redirect still in flight
    rst = 1'b1;
    // Strobes of the cycle before reset is sampled are still due
    idle(1);
    clear_model();
    idle(2);
    rst = 1'b0;
    idle(6);
    for (int i = 1; i < 32; i++) begin
      do_alu_r(OR, REG_AW'(i), REG_AW'(i), '0);
    end
    drain();
  endtask

  initial begin
    #(CLK_PER * (RST_CYC + 20 * N_INSTR + 100));
    stop_run($sformatf("error at %0t: the run timed out", $time));
  end

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc    = '0;
    pc       = '0;
    clear_model();
    repeat (RST_CYC) @(posedge bus);
    #2;
    rst = 1'b0;
    test_alu();
    test_chain();
    test_upper();
    test_branch();
    test_jump();
    test_reset();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* logic/core_top.sv */
module core_top
  import core_pkg::*;
#(
  parameter int PC_W = 16
) (
  input  logic              bus,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [XLEN-1:0]   in_instr,
  input  logic [PC_W-1:0]   in_pc,
  output logic              redirect_valid,
  output logic [PC_W-1:0]   redirect_pc,
  output logic              res_valid,
  output logic [REG_AW-1:0] res_rd,
  output logic [XLEN-1:0]   res_value
);

  // Register file read side
  logic [REG_AW-1:0] rf_addr_a, rf_addr_b;
  logic [XLEN-1:0]   rf_data_a, rf_data_b;

  // Decode to execute
  logic              ex_valid, ex_link, ex_wen;
  alu_op_e           ex_op;
  logic [XLEN-1:0]   ex_a, ex_b;
  logic [REG_AW-1:0] ex_rd;
  logic [PC_W-1:0]   ex_pc_link;

  // Execute forward and execute to result
  logic              fwd_ex_wen;
  logic [REG_AW-1:0] fwd_ex_rd;
  logic [XLEN-1:0]   fwd_ex_value;
  logic              wb_valid, wb_wen;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_value;

  // Register file write side
  logic              rf_wen;
  logic [REG_AW-1:0] rf_addr;
  logic [XLEN-1:0]   rf_data;

  decode #(.PC_W(PC_W)) u_decode (
    .bus, .rst, .in_valid, .in_instr, .in_pc,
    .rf_addr_a, .rf_addr_b, .rf_data_a, .rf_data_b,
    .fwd_ex_wen, .fwd_ex_rd, .fwd_ex_value,
    // Result stage forward comes from the execute/result register
    .fwd_wb_wen(wb_wen), .fwd_wb_rd(wb_rd), .fwd_wb_value(wb_value),
    .ex_valid, .ex_op, .ex_a, .ex_b, .ex_rd, .ex_link, .ex_pc_link, .ex_wen,
    .redirect_valid, .redirect_pc
  );

  execute #(.PC_W(PC_W)) u_execute (
    .bus, .rst,
    .ex_valid, .ex_op, .ex_a, .ex_b, .ex_rd, .ex_link, .ex_pc_link, .ex_wen,
    .fwd_ex_wen, .fwd_ex_rd, .fwd_ex_value,
    .wb_valid, .wb_wen, .wb_rd, .wb_value
  );

  result u_result (
    .bus, .rst, .wb_valid, .wb_wen, .wb_rd, .wb_value,
    .rf_wen, .rf_addr, .rf_data, .res_valid, .res_rd, .res_value
  );

  reg_file u_reg_file (
    .bus, .rst,
    .rd_addr_a(rf_addr_a), .rd_addr_b(rf_addr_b),
    .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
    .wr_en(rf_wen), .wr_addr(rf_addr), .wr_data(rf_data)
  );

endmodule

/* logic/result.sv */
module result
  import core_pkg::*;
(
  input  logic              bus,
  input  logic              rst,
  input  logic              wb_valid,
  input  logic              wb_wen,
  input  logic [REG_AW-1:0] wb_rd,
  input  logic [XLEN-1:0]   wb_value,
  output logic              rf_wen,
  output logic [REG_AW-1:0] rf_addr,
  output logic [XLEN-1:0]   rf_data,
  output logic              res_valid,
  output logic [REG_AW-1:0] res_rd,
  output logic [XLEN-1:0]   res_value
);

  // Only register writes are reported
  always_ff @(posedge bus) begin
    if (rst) begin
      rf_wen <= 1'b0;
    end else begin
      rf_wen <= wb_valid && wb_wen;
    end
  end

  always_ff @(posedge bus) begin
    rf_addr <= wb_rd;
    rf_data <= wb_value;
  end

  // Strobe and register-file write share one cycle
  assign res_valid = rf_wen;
  assign res_rd    = rf_addr;
  assign res_value = rf_data;

endmodule

/* logic/execute.sv */
module execute
  import core_pkg::*;
#(
  parameter int PC_W = 16
) (
  input  logic              bus,
  input  logic              rst,
  input  logic              ex_valid,
  input  alu_op_e           ex_op,
  input  logic [XLEN-1:0]   ex_a,
  input  logic [XLEN-1:0]   ex_b,
  input  logic [REG_AW-1:0] ex_rd,
  input  logic              ex_link,
  input  logic [PC_W-1:0]   ex_pc_link,
  input  logic              ex_wen,
  output logic              fwd_ex_wen,
  output logic [REG_AW-1:0] fwd_ex_rd,
  output logic [XLEN-1:0]   fwd_ex_value,
  output logic              wb_valid,
  output logic              wb_wen,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_value
);

  localparam int SHW = $clog2(XLEN);

  logic [SHW-1:0]  shamt;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] ex_result;

  assign shamt = ex_b[SHW-1:0];

  ////////////////////
  // ALU

  always_comb begin
    case (ex_op)
      ADD:     alu_out = ex_a + ex_b;
      SUB:     alu_out = ex_a - ex_b;
      SLL:     alu_out = ex_a << shamt;
      SLT:     alu_out = XLEN'($signed(ex_a) < $signed(ex_b));
      SLTU:    alu_out = XLEN'(ex_a < ex_b);
      XOR:     alu_out = ex_a ^ ex_b;
      SRL:     alu_out = ex_a >> shamt;
      SRA:     alu_out = $signed(ex_a) >>> shamt;
      OR:      alu_out = ex_a | ex_b;
      AND:     alu_out = ex_a & ex_b;
      PASS_B:  alu_out = ex_b;
      default: alu_out = '0;
    endcase
  end

  // Jumps write the return address
  assign ex_result = ex_link ? XLEN'(ex_pc_link) : alu_out;

  // Back to decode in the same cycle
  assign fwd_ex_wen   = ex_valid && ex_wen;
  assign fwd_ex_rd    = ex_rd;
  assign fwd_ex_value = ex_result;

  ////////////////////
  // Execute/result register

  always_ff @(posedge bus) begin
    if (rst) begin
      wb_valid <= 1'b0;
      wb_wen   <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
      wb_wen   <= ex_valid && ex_wen;
    end
  end

  always_ff @(posedge bus) begin
    wb_rd    <= ex_rd;
    wb_value <= ex_result;
  end

endmodule

/* logic/decode.sv */
module decode
  import core_pkg::*;
#(
  parameter int PC_W = 16
) (
  input  logic              bus,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [XLEN-1:0]   in_instr,
  input  logic [PC_W-1:0]   in_pc,
  output logic [REG_AW-1:0] rf_addr_a,
  output logic [REG_AW-1:0] rf_addr_b,
  input  logic [XLEN-1:0]   rf_data_a,
  input  logic [XLEN-1:0]   rf_data_b,
  input  logic              fwd_ex_wen,
  input  logic [REG_AW-1:0] fwd_ex_rd,
  input  logic [XLEN-1:0]   fwd_ex_value,
  input  logic              fwd_wb_wen,
  input  logic [REG_AW-1:0] fwd_wb_rd,
  input  logic [XLEN-1:0]   fwd_wb_value,
  output logic              ex_valid,
  output alu_op_e           ex_op,
  output logic [XLEN-1:0]   ex_a,
  output logic [XLEN-1:0]   ex_b,
  output logic [REG_AW-1:0] ex_rd,
  output logic              ex_link,
  output logic [PC_W-1:0]   ex_pc_link,
  output logic              ex_wen,
  output logic              redirect_valid,
  output logic [PC_W-1:0]   redirect_pc
);

  opcode_e           opcode;
  br_cond_e          cond_sel;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]   imm_i, imm_u, imm_b, imm_j;
  logic [XLEN-1:0]   rs1_val, rs2_val;
  logic              legal, wr_rd, link, is_branch, is_jump;
  logic              cond_true, live, take, flush_pend;
  alu_op_e           op;
  logic [XLEN-1:0]   op_a, op_b;
  logic [PC_W-1:0]   target, pc_link, jalr_sum;

  ////////////////////
  // Fields and immediates

  assign opcode   = opcode_e'(in_instr[OPC_LSB +: 7]);
  assign funct3   = in_instr[F3_LSB +: 3];
  assign funct7   = in_instr[F7_LSB +: 7];
  assign rd       = in_instr[RD_LSB +: REG_AW];
  assign rs1      = in_instr[RS1_LSB +: REG_AW];
  assign rs2      = in_instr[RS2_LSB +: REG_AW];
  assign cond_sel = br_cond_e'(funct3);

  assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
  assign imm_u = {in_instr[31:12], 12'b0};
  assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
                  in_instr[11:8], 1'b0};
  assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12], in_instr[20],
                  in_instr[30:21], 1'b0};

  assign rf_addr_a = rs1;
  assign rf_addr_b = rs2;

  // funct3/funct7 to ALU function, SUB only exists in the register form
  function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt,
                                      input logic is_reg);
    case (f3)
      F3_ADD:  return (is_reg && alt) ? SUB : ADD;
      F3_SLL:  return SLL;
      F3_SLT:  return SLT;
      F3_SLTU: return SLTU;
      F3_XOR:  return XOR;
      F3_SR:   return alt ? SRA : SRL;
      F3_OR:   return OR;
      F3_AND:  return AND;
      default: return ADD;
    endcase
  endfunction

  ////////////////////
  // Operand forwarding

  // Youngest producer wins, x0 stays zero
  function automatic logic [XLEN-1:0] forward(input logic [REG_AW-1:0] addr,
                                              input logic [XLEN-1:0] rf_val);
    logic [XLEN-1:0] val;
    val = rf_val;
    if (addr == '0) begin
      val = '0;
    end else if (fwd_ex_wen && fwd_ex_rd == addr) begin
      val = fwd_ex_value;
    end else if (fwd_wb_wen && fwd_wb_rd == addr) begin
      val = fwd_wb_value;
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = forward(rs1, rf_data_a);
    rs2_val = forward(rs2, rf_data_b);
  end

  ////////////////////
  // Control

  assign jalr_sum = rs1_val[PC_W-1:0] + imm_i[PC_W-1:0];
  assign pc_link  = in_pc + PC_W'(4);

  always_comb begin
    legal     = 1'b1;
    wr_rd     = 1'b0;
    link      = 1'b0;
    is_branch = 1'b0;
    is_jump   = 1'b0;
    op        = ADD;
    op_a      = rs1_val;
    op_b      = rs2_val;
    target    = in_pc + imm_b[PC_W-1:0];
    case (opcode)
      OP: begin
        wr_rd = 1'b1;
        op    = alu_map(funct3, funct7 == F7_ALT, 1'b1);
      end
      OP_IMM: begin
        wr_rd = 1'b1;
        op    = alu_map(funct3, funct7 == F7_ALT, 1'b0);
        op_b  = imm_i;
      end
      LUI: begin
        wr_rd = 1'b1;
        op    = PASS_B;
        op_b  = imm_u;
      end
      AUIPC: begin
        wr_rd = 1'b1;
        op_a  = XLEN'(in_pc);
        op_b  = imm_u;
      end
      BRANCH: is_branch = 1'b1;
      JAL: begin
        wr_rd   = 1'b1;
        link    = 1'b1;
        is_jump = 1'b1;
        target  = in_pc + imm_j[PC_W-1:0];
      end
      JALR: begin
        wr_rd   = 1'b1;
        link    = 1'b1;
        is_jump = 1'b1;
        target  = {jalr_sum[PC_W-1:1], 1'b0};
      end
      // Anything else leaves as a bubble
      default: legal = 1'b0;
    endcase
  end

  // Branch compare on the forwarded operands
  always_comb begin
    case (cond_sel)
      BEQ:     cond_true = (rs1_val == rs2_val);
      BNE:     cond_true = (rs1_val != rs2_val);
      BLT:     cond_true = ($signed(rs1_val) < $signed(rs2_val));
      BGE:     cond_true = ($signed(rs1_val) >= $signed(rs2_val));
      BLTU:    cond_true = (rs1_val < rs2_val);
      BGEU:    cond_true = (rs1_val >= rs2_val);
      default: cond_true = 1'b0;
    endcase
  end

  // The slot after a taken branch or jump is dropped
  assign live = in_valid && !flush_pend && legal;
  assign take = live && (is_jump || (is_branch && cond_true));

  ////////////////////
  // Decode/execute register

  always_ff @(posedge bus) begin
    if (rst) begin
      ex_valid       <= 1'b0;
      ex_wen         <= 1'b0;
      redirect_valid <= 1'b0;
      flush_pend     <= 1'b0;
    end else begin
      ex_valid       <= live;
      ex_wen         <= live && wr_rd && rd != '0;
      redirect_valid <= take;
      // Flag holds until the next strobe consumes it
      if (in_valid) begin
        flush_pend <= take;
      end
    end
  end

  always_ff @(posedge bus) begin
    ex_op       <= op;
    ex_a        <= op_a;
    ex_b        <= op_b;
    ex_rd       <= rd;
    ex_link     <= link;
    ex_pc_link  <= pc_link;
    redirect_pc <= target;
  end

endmodule

/* logic/reg_file.sv */
module reg_file
  import core_pkg::*;
(
  input  logic              bus,
  input  logic              rst,
  input  logic [REG_AW-1:0] rd_addr_a,
  input  logic [REG_AW-1:0] rd_addr_b,
  output logic [XLEN-1:0]   rd_data_a,
  output logic [XLEN-1:0]   rd_data_b,
  input  logic              wr_en,
  input  logic [REG_AW-1:0] wr_addr,
  input  logic [XLEN-1:0]   wr_data
);

  // x1 to x31, x0 is not stored
  logic [XLEN-1:0] regs [1:(1 << REG_AW) - 1];

  always_ff @(posedge bus) begin
    if (rst) begin
      for (int i = 1; i < (1 << REG_AW); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Same-cycle write goes straight to the reader
  assign rd_data_a = (rd_addr_a == '0) ? '0 :
                     (wr_en && wr_addr == rd_addr_a) ? wr_data :
                     regs[rd_addr_a];

  assign rd_data_b = (rd_addr_b == '0) ? '0 :
                     (wr_en && wr_addr == rd_addr_b) ? wr_data :
                     regs[rd_addr_b];

endmodule

/* logic/core_pkg.sv */
package core_pkg;

  ////////////////////
  // Widths

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  ////////////////////
  // Instruction fields

  // Bit positions of the fixed fields
  localparam int OPC_LSB = 0;
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

  // funct7 that selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // funct3 of the ALU group
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  ////////////////////
  // Major opcodes

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_e;

  // ALU functions, PASS_B carries the LUI immediate
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_e;

  // Branch conditions, encoded as their funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_cond_e;

endpackage
